// File: Makefile
.PHONY: lint sim clean

# Lint the RTL top level on its own
lint:
	verilator --lint-only --timing -f a2_glue.f --top-module a2_glue

# Build and run the testbench, then look for the pass line in the log
sim:
	verilator --binary --timing --assert -f a2_glue.f --top-module tb_a2_glue -Mdir obj_dir
	./obj_dir/Vtb_a2_glue | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: a2_glue.f
verilog/a2_pkg.sv
verilog/hdd_request_ctrl.sv
verilog/disk_mount_track.sv
verilog/main_aux_ram.sv
verilog/joy_map.sv
verilog/a2_glue.sv
verification/tb_a2_glue.sv

// File: verification/tb_a2_glue.sv
`timescale 1ns/100ps

module tb_a2_glue;

	localparam int CYCLE_LIMIT = 6000;

	logic                clk_sys;
	logic                dd_reset;
	logic                hdd_read;
	logic                hdd_write;
	logic                sd_ack_hdd;
	logic                sd_rd_hdd;
	logic                sd_wr_hdd;
	logic                cpu_wait;
	a2_pkg::drive_vec_t  img_mounted;
	a2_pkg::img_size_t   img_size;
	logic                img_readonly;
	logic                hdd_mounted;
	logic                hdd_protect;
	a2_pkg::floppy_vec_t disk_mount;
	a2_pkg::floppy_vec_t disk_change;
	a2_pkg::ram_addr_t   ram_addr;
	a2_pkg::ram_byte_t   ram_din;
	logic                ram_we;
	logic                ram_aux;
	a2_pkg::ram_word_t   ram_dout;
	a2_pkg::joy_analog_t joystick_analog;
	a2_pkg::joy_dig_t    joystick_dig;
	a2_pkg::joy_axis_t   paddle;
	logic                analog_swap;
	logic                pdl_sel_hi;
	logic                pdl_sel_lo;
	a2_pkg::joy_analog_t joy_an;
	a2_pkg::joy_dig_t    joy_dig_out;

	int                  value_errors;
	int                  protocol_errors;
	int                  cycle_count;
	logic                want_rd;
	logic                want_wr;
	logic                exp_hdd_mounted;
	logic                exp_hdd_protect;
	a2_pkg::floppy_vec_t exp_mount;
	a2_pkg::floppy_vec_t exp_change;
	a2_pkg::ram_byte_t   main_model [int];
	a2_pkg::ram_byte_t   aux_model [int];
	a2_pkg::ram_addr_t   written_addrs [$];

	a2_glue uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

	// ==============================
	// Protocol checks
	// ==============================
	// Only the levels of the request in flight may rise
	a_only_asked: assert property (@(posedge clk_sys) disable iff (dd_reset)
		(!sd_rd_hdd || want_rd) && (!sd_wr_hdd || want_wr))
		else begin
			protocol_errors++;
			$display("hdd request level raised that the test did not ask for");
		end

	a_wait_in_txn: assert property (@(posedge clk_sys) disable iff (dd_reset)
		cpu_wait |-> (want_rd || want_wr))
		else begin
			protocol_errors++;
			$display("cpu_wait high outside a hard-disk transaction");
		end

	task automatic check_value(input string test_name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("error %s: expected %0h, actual %0h", test_name, expected, actual);
		end
	endtask

	// SD server answers after 1 to 8 cycles and holds ack for 1 to 8 more
	task automatic hdd_transaction(input logic rd, input logic wr);
		int raise_delay;
		int drop_delay;
		raise_delay = 1 + $urandom % 8;
		drop_delay  = 1 + $urandom % 8;
		want_rd   = rd;
		want_wr   = wr;
		hdd_read  = rd;
		hdd_write = wr;
		@(negedge clk_sys);
		hdd_read  = 1'b0;
		hdd_write = 1'b0;
		check_value("hdd pending", 0, 32'({sd_rd_hdd, sd_wr_hdd, cpu_wait}));
		@(negedge clk_sys);
		check_value("hdd request rise", 32'({rd, wr, 1'b1}), 32'({sd_rd_hdd, sd_wr_hdd, cpu_wait}));
		repeat (raise_delay) begin
			@(negedge clk_sys);
			check_value("hdd request hold", 32'({rd, wr, 1'b1}),
				32'({sd_rd_hdd, sd_wr_hdd, cpu_wait}));
		end
		sd_ack_hdd = 1'b1;
		@(negedge clk_sys);
		check_value("hdd ack sampled", 32'({rd, wr, 1'b1}), 32'({sd_rd_hdd, sd_wr_hdd, cpu_wait}));
		@(negedge clk_sys);
		check_value("hdd request fall", 1, 32'({sd_rd_hdd, sd_wr_hdd, cpu_wait}));
		repeat (drop_delay) begin
			@(negedge clk_sys);
			check_value("hdd wait hold", 1, 32'({sd_rd_hdd, sd_wr_hdd, cpu_wait}));
		end
		sd_ack_hdd = 1'b0;
		@(negedge clk_sys);
		check_value("hdd ack low sampled", 1, 32'({sd_rd_hdd, sd_wr_hdd, cpu_wait}));
		@(negedge clk_sys);
		check_value("hdd wait fall", 0, 32'({sd_rd_hdd, sd_wr_hdd, cpu_wait}));
		want_rd = 1'b0;
		want_wr = 1'b0;
	endtask

	task automatic mount_pulse(input int slot, input logic nonzero, input logic ro);
		logic [31:0] rnd;
		rnd          = $urandom;
		img_mounted  = 3'b001 << slot;
		img_size     = nonzero ? (64'h1 << rnd[5:0]) : '0;
		img_readonly = ro;
		if (slot == a2_pkg::IDX_HDD) begin
			exp_hdd_mounted = nonzero;
			exp_hdd_protect = ro;
		end else if (slot == a2_pkg::IDX_FLOPPY1) begin
			exp_mount[0]  = nonzero;
			exp_change[0] = ~exp_change[0];
		end else begin
			exp_mount[1]  = nonzero;
			exp_change[1] = ~exp_change[1];
		end
		@(negedge clk_sys);
		check_value("mount update", 32'({exp_hdd_mounted, exp_hdd_protect, exp_mount, exp_change}),
			32'({hdd_mounted, hdd_protect, disk_mount, disk_change}));
		// No pulse, so size and readonly noise must be ignored
		img_mounted  = '0;
		img_size     = {rnd, ~rnd};
		img_readonly = rnd[9];
		@(negedge clk_sys);
		check_value("mount hold", 32'({exp_hdd_mounted, exp_hdd_protect, exp_mount, exp_change}),
			32'({hdd_mounted, hdd_protect, disk_mount, disk_change}));
	endtask

	task automatic ram_access(input a2_pkg::ram_addr_t addr, input logic we, input logic aux,
			input a2_pkg::ram_byte_t din);
		int main_key;
		int aux_key;
		main_key = int'(addr);
		aux_key  = int'(addr[15:0]);
		ram_addr = addr;
		ram_we   = we;
		ram_aux  = aux;
		ram_din  = din;
		@(negedge clk_sys);
		if (we && !aux)
			check_value("ram main write-through", 32'(din), 32'(ram_dout[7:0]));
		else if (main_model.exists(main_key))
			check_value("ram main read", 32'(main_model[main_key]), 32'(ram_dout[7:0]));
		if (we && aux)
			check_value("ram aux write-through", 32'(din), 32'(ram_dout[15:8]));
		else if (aux_model.exists(aux_key))
			check_value("ram aux read", 32'(aux_model[aux_key]), 32'(ram_dout[15:8]));
		if (we && !aux)
			main_model[main_key] = din;
		if (we && aux)
			aux_model[aux_key] = din;
		ram_we = 1'b0;
	endtask

	task automatic joy_vector();
		logic [31:0]         rnd_a;
		logic [31:0]         rnd_b;
		a2_pkg::joy_axis_t   pdl_val;
		a2_pkg::joy_axis_t   sw_hi;
		a2_pkg::joy_axis_t   sw_lo;
		a2_pkg::joy_analog_t exp_an;
		a2_pkg::joy_dig_t    exp_dig;
		rnd_a = $urandom;
		rnd_b = $urandom;
		// Zero bytes often so the direction masks get exercised
		joystick_analog = {rnd_b[0] ? 8'h00 : rnd_a[15:8], rnd_b[1] ? 8'h00 : rnd_a[7:0]};
		joystick_dig    = rnd_a[21:16];
		paddle          = rnd_a[31:24];
		analog_swap     = rnd_b[2];
		pdl_sel_hi      = rnd_b[3];
		pdl_sel_lo      = rnd_b[4];
		pdl_val = paddle ^ 8'h80;
		if (analog_swap) begin
			sw_hi = joystick_analog[15:8];
			sw_lo = joystick_analog[7:0];
		end else begin
			sw_hi = joystick_analog[7:0];
			sw_lo = joystick_analog[15:8];
		end
		exp_an[15:8] = pdl_sel_hi ? pdl_val : sw_hi;
		exp_an[7:0]  = pdl_sel_lo ? pdl_val : sw_lo;
		exp_dig = joystick_dig;
		if (sw_lo != 8'h00)
			exp_dig[3:2] = 2'b00;
		if (sw_hi != 8'h00)
			exp_dig[1:0] = 2'b00;
		@(negedge clk_sys);
		check_value("joy analog", 32'(exp_an), 32'(joy_an));
		check_value("joy digital", 32'(exp_dig), 32'(joy_dig_out));
	endtask

	initial begin
		a2_pkg::ram_addr_t addr;
		logic [31:0]       rnd;
		logic [1:0]        up;
		int                kind;
		int                idx;
		void'($urandom(32'h757a_6404));
		value_errors    = 0;
		protocol_errors = 0;
		want_rd         = 1'b0;
		want_wr         = 1'b0;
		exp_hdd_mounted = 1'b0;
		exp_hdd_protect = 1'b0;
		exp_mount       = '0;
		exp_change      = '0;
		dd_reset        = 1'b1;
		hdd_read        = 1'b0;
		hdd_write       = 1'b0;
		sd_ack_hdd      = 1'b0;
		img_mounted     = '0;
		img_size        = '0;
		img_readonly    = 1'b0;
		ram_addr        = '0;
		ram_din         = '0;
		ram_we          = 1'b0;
		ram_aux         = 1'b0;
		joystick_analog = '0;
		joystick_dig    = '0;
		paddle          = '0;
		analog_swap     = 1'b0;
		pdl_sel_hi      = 1'b0;
		pdl_sel_lo      = 1'b0;
		repeat (16) @(negedge clk_sys);
		dd_reset = 1'b0;
		check_value("reset outputs", 0, 32'({sd_rd_hdd, sd_wr_hdd, cpu_wait, hdd_mounted,
			hdd_protect, disk_mount, disk_change}));

		// Read only, write only or both at once
		repeat (40) begin
			kind = $urandom % 3;
			hdd_transaction(kind != 1, kind != 0);
			@(negedge clk_sys);
		end

		repeat (30) begin
			rnd = $urandom;
			mount_pulse(int'(rnd % 3), rnd[12], rnd[13]);
		end

		// ==============================
		// RAM writes then read-back
		// ==============================
		repeat (200) begin
			rnd = $urandom;
			up  = rnd[17:16];
			if (!rnd[20] && up == 2'b11)
				up = 2'b10;
			addr = {up, 6'b000000, rnd[9:0]};
			written_addrs.push_back(addr);
			ram_access(addr, 1'b1, rnd[20], rnd[31:24]);
		end
		// Fresh upper bits on read-back, the aux lane must not care
		repeat (200) begin
			rnd  = $urandom;
			idx  = $urandom % written_addrs.size();
			addr = written_addrs[idx];
			up   = rnd[17:16];
			if (up == 2'b11)
				up = addr[17:16];
			ram_access({up, addr[15:0]}, 1'b0, 1'b0, 8'h00);
		end

		repeat (200) joy_vector();

		$display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: verilog/a2_glue.sv
`timescale 1ns/100ps

module a2_glue (
	input  logic                 clk_sys,
	input  logic                 dd_reset,

	// Hard disk requests
	input  logic                 hdd_read,
	input  logic                 hdd_write,
	input  logic                 sd_ack_hdd,
	output logic                 sd_rd_hdd,
	output logic                 sd_wr_hdd,
	output logic                 cpu_wait,

	// Image mounts
	input  a2_pkg::drive_vec_t   img_mounted,
	input  a2_pkg::img_size_t    img_size,
	input  logic                 img_readonly,
	output logic                 hdd_mounted,
	output logic                 hdd_protect,
	output a2_pkg::floppy_vec_t  disk_mount,
	output a2_pkg::floppy_vec_t  disk_change,

	// Main and aux RAM
	input  a2_pkg::ram_addr_t    ram_addr,
	input  a2_pkg::ram_byte_t    ram_din,
	input  logic                 ram_we,
	input  logic                 ram_aux,
	output a2_pkg::ram_word_t    ram_dout,

	// Joystick and paddle
	input  a2_pkg::joy_analog_t  joystick_analog,
	input  a2_pkg::joy_dig_t     joystick_dig,
	input  a2_pkg::joy_axis_t    paddle,
	input  logic                 analog_swap,
	input  logic                 pdl_sel_hi,
	input  logic                 pdl_sel_lo,
	output a2_pkg::joy_analog_t  joy_an,
	output a2_pkg::joy_dig_t     joy_dig_out
);

	hdd_request_ctrl u_hdd_request_ctrl (
		.clk_sys    (clk_sys),
		.dd_reset   (dd_reset),
		.hdd_read   (hdd_read),
		.hdd_write  (hdd_write),
		.sd_ack_hdd (sd_ack_hdd),
		.sd_rd_hdd  (sd_rd_hdd),
		.sd_wr_hdd  (sd_wr_hdd),
		.cpu_wait   (cpu_wait)
	);

	disk_mount_track u_disk_mount_track (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.img_readonly (img_readonly),
		.hdd_mounted  (hdd_mounted),
		.hdd_protect  (hdd_protect),
		.disk_mount   (disk_mount),
		.disk_change  (disk_change)
	);

	main_aux_ram u_main_aux_ram (
		.clk_sys  (clk_sys),
		.ram_addr (ram_addr),
		.ram_din  (ram_din),
		.ram_we   (ram_we),
		.ram_aux  (ram_aux),
		.ram_dout (ram_dout)
	);

	joy_map u_joy_map (
		.joystick_analog (joystick_analog),
		.joystick_dig    (joystick_dig),
		.paddle          (paddle),
		.analog_swap     (analog_swap),
		.pdl_sel_hi      (pdl_sel_hi),
		.pdl_sel_lo      (pdl_sel_lo),
		.joy_an          (joy_an),
		.joy_dig_out     (joy_dig_out)
	);

endmodule

// File: verilog/a2_pkg.sv
package a2_pkg;

	// ==============================
	// Memory
	// ==============================
	localparam int RAM_ADDR_W = 18;
	localparam int AUX_ADDR_W = 16;
	localparam int RAM_BYTE_W = 8;
	localparam int MAIN_DEPTH = 196608;
	localparam int AUX_DEPTH  = 65536;

	typedef logic [RAM_ADDR_W-1:0]   ram_addr_t;
	typedef logic [AUX_ADDR_W-1:0]   aux_addr_t;
	typedef logic [RAM_BYTE_W-1:0]   ram_byte_t;
	// Main bank in the low byte, aux bank in the high byte
	typedef logic [2*RAM_BYTE_W-1:0] ram_word_t;

	// ==============================
	// Disk images
	// ==============================
	localparam int IDX_FLOPPY1 = 0;
	localparam int IDX_HDD     = 1;
	localparam int IDX_FLOPPY2 = 2;

	typedef logic [63:0] img_size_t;
	typedef logic [2:0]  drive_vec_t;
	typedef logic [1:0]  floppy_vec_t;

	typedef enum logic [0:0] {
		HDD_IDLE = 1'b0,
		HDD_BUSY = 1'b1
	} hdd_state_t;

	// ==============================
	// Joystick
	// ==============================
	typedef logic [7:0]  joy_axis_t;
	typedef logic [15:0] joy_analog_t;
	typedef logic [5:0]  joy_dig_t;

endpackage

// File: verilog/disk_mount_track.sv
`timescale 1ns/100ps

module disk_mount_track (
	input  logic                clk_sys,
	input  logic                dd_reset,
	input  a2_pkg::drive_vec_t  img_mounted,
	input  a2_pkg::img_size_t   img_size,
	input  logic                img_readonly,
	output logic                hdd_mounted,
	output logic                hdd_protect,
	output a2_pkg::floppy_vec_t disk_mount,
	output a2_pkg::floppy_vec_t disk_change
);

	a2_pkg::floppy_vec_t floppy_pulse;
	logic                img_present;

	// Floppy 1 in bit 0, floppy 2 in bit 1
	assign floppy_pulse = {img_mounted[a2_pkg::IDX_FLOPPY2], img_mounted[a2_pkg::IDX_FLOPPY1]};
	assign img_present  = (img_size != '0);

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			hdd_mounted <= 1'b0;
			hdd_protect <= 1'b0;
			disk_mount  <= '0;
			disk_change <= '0;
		end else begin
			if (img_mounted[a2_pkg::IDX_HDD]) begin
				hdd_mounted <= img_present;
				hdd_protect <= img_readonly;
			end
			for (int f = 0; f < 2; f++) begin
				if (floppy_pulse[f]) begin
					disk_mount[f]  <= img_present;
					disk_change[f] <= ~disk_change[f];
				end
			end
		end
	end

	// Change toggles are what the floppy engine watches to reload a track
	for (genvar g = 0; g < 2; g++) begin : g_change_chk
		a_change_own_slot: assert property (@(posedge clk_sys) disable iff (dd_reset)
			($changed(disk_change[g]) && !$past(dd_reset)) |-> $past(floppy_pulse[g]))
			else $error("floppy %0d change bit toggled without its mount pulse", g);
	end

endmodule

// File: verilog/hdd_request_ctrl.sv
`timescale 1ns/100ps

module hdd_request_ctrl (
	input  logic clk_sys,
	input  logic dd_reset,
	input  logic hdd_read,
	input  logic hdd_write,
	input  logic sd_ack_hdd,
	output logic sd_rd_hdd,
	output logic sd_wr_hdd,
	output logic cpu_wait
);

	a2_pkg::hdd_state_t state;
	logic               rd_pending;
	logic               wr_pending;
	logic               ack_d;
	logic               req_up;

	// Requests still raised means we are waiting for the ack to rise
	assign req_up = sd_rd_hdd | sd_wr_hdd;

	// ==============================
	// Request FSM
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			state      <= a2_pkg::HDD_IDLE;
			rd_pending <= 1'b0;
			wr_pending <= 1'b0;
			ack_d      <= 1'b0;
			sd_rd_hdd  <= 1'b0;
			sd_wr_hdd  <= 1'b0;
			cpu_wait   <= 1'b0;
		end else begin
			ack_d <= sd_ack_hdd;

			// Pulses stack up until the server acks, so late ones merge
			rd_pending <= rd_pending | hdd_read;
			wr_pending <= wr_pending | hdd_write;

			case (state)
				a2_pkg::HDD_IDLE: begin
					if (rd_pending | wr_pending) begin
						state     <= a2_pkg::HDD_BUSY;
						sd_rd_hdd <= rd_pending;
						sd_wr_hdd <= wr_pending;
						cpu_wait  <= 1'b1;
					end
				end
				a2_pkg::HDD_BUSY: begin
					if (req_up && ack_d) begin
						// Ack seen high on the last edge
						rd_pending <= 1'b0;
						wr_pending <= 1'b0;
						sd_rd_hdd  <= 1'b0;
						sd_wr_hdd  <= 1'b0;
					end else if (!req_up && !ack_d) begin
						// Ack has dropped again, release the CPU
						state    <= a2_pkg::HDD_IDLE;
						cpu_wait <= 1'b0;
					end
				end
				default: state <= a2_pkg::HDD_IDLE;
			endcase
		end
	end

	// ==============================
	// Checks
	// ==============================
	a_req_under_wait: assert property (@(posedge clk_sys) disable iff (dd_reset)
		(sd_rd_hdd || sd_wr_hdd) |-> cpu_wait)
		else $error("hdd request raised without cpu_wait");

	a_wait_after_ack: assert property (@(posedge clk_sys) disable iff (dd_reset)
		($fell(cpu_wait) && !$past(dd_reset)) |-> !sd_ack_hdd)
		else $error("cpu_wait released while sd ack still high");

endmodule

// File: verilog/joy_map.sv
`timescale 1ns/100ps

module joy_map (
	input  a2_pkg::joy_analog_t joystick_analog,
	input  a2_pkg::joy_dig_t    joystick_dig,
	input  a2_pkg::joy_axis_t   paddle,
	input  logic                analog_swap,
	input  logic                pdl_sel_hi,
	input  logic                pdl_sel_lo,
	output a2_pkg::joy_analog_t joy_an,
	output a2_pkg::joy_dig_t    joy_dig_out
);

	a2_pkg::joy_axis_t   pdl;
	a2_pkg::joy_analog_t joy_swp;
	logic                lo_idle;
	logic                hi_idle;

	// Paddle arrives signed around zero, the core wants it offset
	assign pdl = {~paddle[7], paddle[6:0]};

	// Byte order is reversed unless the swap option is set
	assign joy_swp = analog_swap ? joystick_analog
	                             : {joystick_analog[7:0], joystick_analog[15:8]};

	assign joy_an = {pdl_sel_hi ? pdl : joy_swp[15:8],
	                 pdl_sel_lo ? pdl : joy_swp[7:0]};

	// Digital directions only count while the stick is centred
	assign lo_idle = ~|joy_swp[7:0];
	assign hi_idle = ~|joy_swp[15:8];

	assign joy_dig_out = joystick_dig & {2'b11, {2{lo_idle}}, {2{hi_idle}}};

endmodule

// File: verilog/main_aux_ram.sv
`timescale 1ns/100ps

module main_aux_ram (
	input  logic              clk_sys,
	input  a2_pkg::ram_addr_t ram_addr,
	input  a2_pkg::ram_byte_t ram_din,
	input  logic              ram_we,
	input  logic              ram_aux,
	output a2_pkg::ram_word_t ram_dout
);

	a2_pkg::ram_byte_t main_mem [a2_pkg::MAIN_DEPTH];
	a2_pkg::ram_byte_t aux_mem  [a2_pkg::AUX_DEPTH];

	a2_pkg::aux_addr_t aux_addr;
	logic              main_we;
	logic              aux_we;

	// Aux bank only sees the low 64K, upper address bits fold away
	assign aux_addr = ram_addr[15:0];
	assign main_we  = ram_we & ~ram_aux;
	assign aux_we   = ram_we & ram_aux;

	// ==============================
	// Main bank, low lane
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (main_we) begin
			main_mem[ram_addr] <= ram_din;
			ram_dout[7:0]      <= ram_din;
		end else begin
			ram_dout[7:0] <= main_mem[ram_addr];
		end
	end

	// ==============================
	// Aux bank, high lane
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (aux_we) begin
			aux_mem[aux_addr] <= ram_din;
			ram_dout[15:8]    <= ram_din;
		end else begin
			ram_dout[15:8] <= aux_mem[aux_addr];
		end
	end

endmodule
